// File: verilog.f
fpuPkg.sv
fpuIssue.sv
fpuControl.sv
fpuStepCounter.sv
fpuConvert.sv
fpuMultiply.sv
fpuResult.sv
fpuExecute.sv
fpuExecute_checker.sv
fpuExecuteTb.sv

// File: run.sh
#!/bin/bash
# build the FPU execute testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module fpuExecuteTb -f verilog.f -o fpuExecuteSim

# simulation exit status alone is not trusted, the output decides
output=$(./obj_dir/fpuExecuteSim 2>&1) || true
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi

// File: fpuExecuteTb.sv
/*
 * fpuExecuteTb
 * directed tests for the FPU execute slave covering lane choice,
 * predication, multiply, packed multiply, conversions and exHold
 */
`default_nettype none

module fpuExecuteTb;
	timeunit 1ns;
	timeprecision 1ps;
	import fpuPkg::*;

	localparam logic [7:0] Fpu3Cmd  = {CondAlways, UcmdFpu3};
	localparam logic [7:0] FldcxCmd = {CondAlways, UcmdFldcx};
	localparam logic [7:0] FstcxCmd = {CondAlways, UcmdFstcx};
	localparam logic [7:0] XFmul    = {4'h0, IxtFmul};
	localparam logic [7:0] XFmov    = {4'h0, IxtFmov};
	localparam logic [7:0] XPmul    = {4'h0, IxtPmul};

	logic clock;
	logic reset;
	logic [7:0] opCmdA;
	logic [7:0] opCmdB;
	logic [7:0] ixtA;
	logic [7:0] ixtB;
	fpWord valRsA;
	fpWord valRtA;
	fpWord valRsB;
	fpWord valRtB;
	logic srT;
	logic braFlush;
	logic exHold;
	logic [StatusWidth-1:0] status;
	logic [WordWidth-1:0] result;
	logic [7:0] lfsr;

	fpuExecute #(.MulLatency(MulLatency), .PackedElems(PackedElems)) dut0 (.*);

	bind fpuExecute fpuExecuteChecker checker0 (.clock(clock), .reset(reset),
		.exHold(exHold), .status(status));

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// galois form of x^8 + x^6 + x^5 + x^4 + 1 stepped once per bit
	function automatic logic [63:0] randBits(input int n);
		logic [63:0] value;
		logic lsb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb)
				lfsr = lfsr ^ 8'hB8;
			value = {value[62:0], lsb};
		end
		return value;
	endfunction

	// IEEE repacking of a normal double with the mantissa cut off
	function automatic logic [31:0] toSingle(input real r);
		logic [63:0] d;
		d = $realtobits(r);
		return {d[63], 8'(d[62:52] - 11'd896), d[51:29]};
	endfunction

	function automatic logic [15:0] toHalf(input real r);
		logic [63:0] d;
		d = $realtobits(r);
		return {d[63], 5'(d[62:52] - 11'd1008), d[51:42]};
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check(input logic [63:0] got, input logic [63:0] expected,
			input string what);
		if (got !== expected)
			abortRun($sformatf("CHECK FAILED at %0d ns: %s, got %h, expected %h",
				$time, what, got, expected));
	endtask

	task automatic setLane(input logic lane, input logic [7:0] cmd, input logic [7:0] x,
			input logic [63:0] s, input logic [63:0] t);
		if (lane) begin
			opCmdB = cmd;
			ixtB = x;
			valRsB = s;
			valRtB = t;
		end else begin
			opCmdA = cmd;
			ixtA = x;
			valRsA = s;
			valRtA = t;
		end
	endtask

	// latch on the rising edge and park the lanes on NOP at the falling edge
	task automatic latchCmd();
		@(posedge clock);
		@(negedge clock);
		opCmdA = '0;
		opCmdB = '0;
		braFlush = 1'b0;
	endtask

	task automatic waitOk(output int holds);
		int cycles;
		holds = 0;
		cycles = 0;
		while (status != StatusOk) begin
			if (status == StatusHold)
				holds++;
			cycles++;
			if (cycles > 20)
				abortRun("timeout: status never reached OK within 20 cycles");
			@(negedge clock);
		end
	endtask

	task automatic runCmd(input logic lane, input logic [7:0] cmd, input logic [7:0] x,
			input logic [63:0] s, input logic [63:0] t, input int holds,
			input logic [63:0] expected, input string what);
		int seen;
		setLane(lane, cmd, x, s, t);
		latchCmd();
		waitOk(seen);
		check(64'(seen), 64'(holds), {what, " hold cycles"});
		check(result, expected, what);
	endtask

	task automatic laneTest();
		logic [63:0] a;
		logic [63:0] b;
		a = randBits(16);
		b = randBits(16);
		runCmd(1'b0, Fpu3Cmd, XFmov, a, '0, 0, a, "move on lane A");
		runCmd(1'b1, Fpu3Cmd, XFmov, b, '0, 0, b, "move on lane B");
		setLane(1'b1, Fpu3Cmd, XFmov, b, '0);
		runCmd(1'b0, Fpu3Cmd, XFmov, a, '0, 0, a, "both lanes, A first");
	endtask

	task automatic predicateTest();
		logic [63:0] v;
		logic on;
		for (int c = 0; c < 4; c++) begin
			for (int t = 0; t < 2; t++) begin
				v = randBits(16);
				on = (c == 0) || (c == 2 && t == 1) || (c == 3 && t == 0);
				srT = 1'(t);
				setLane(1'b0, {2'(c), UcmdFpu3}, XFmov, v, '0);
				latchCmd();
				check(64'(status), on ? 64'(StatusOk) : 64'(StatusReady), "predicated status");
				if (on)
					check(result, v, "predicated move");
			end
		end
		srT = 1'b0;
		braFlush = 1'b1;
		setLane(1'b0, Fpu3Cmd, XFmov, 64'h55, '0);
		latchCmd();
		check(64'(status), 64'(StatusReady), "flushed move");
	endtask

	task automatic multiplyTest();
		real a;
		real b;
		for (int i = 0; i < 4; i++) begin
			a = randBits(4) + 1;
			b = randBits(4) + 1;
			if (randBits(1) == 64'd1)
				a = -a;
			runCmd(1'(randBits(1)), Fpu3Cmd, XFmul, $realtobits(a), $realtobits(b), 2,
				$realtobits(a * b), "integer multiply");
		end
		runCmd(1'b0, Fpu3Cmd, XFmul, $realtobits(1024.0), $realtobits(0.125), 2,
			$realtobits(128.0), "power of two multiply");
		runCmd(1'b1, Fpu3Cmd, XFmul, $realtobits(0.5), $realtobits(-0.25), 2,
			$realtobits(-0.125), "negative power of two multiply");
	endtask

	task automatic packedTest();
		// singles -15.0 high and 12.0 low
		runCmd(1'b0, Fpu3Cmd, XPmul, {toSingle(-2.5), toSingle(3.0)},
			{toSingle(6.0), toSingle(4.0)}, 4, {32'hC1700000, 32'h41400000},
			"packed multiply");
	endtask

	task automatic convertTest();
		logic [63:0] third;
		third = $realtobits(1.0 / 3.0);  // low bits are cut on narrowing
		runCmd(1'b0, FldcxCmd, 8'h00, {toSingle(7.5), toSingle(-0.375)}, '0, 0,
			$realtobits(-0.375), "load low single");
		runCmd(1'b1, FldcxCmd, 8'h08, {toSingle(7.5), toSingle(-0.375)}, '0, 0,
			$realtobits(7.5), "load high single");
		runCmd(1'b0, FldcxCmd, 8'h03, {48'h0, toHalf(1.5)}, '0, 0,
			$realtobits(1.5), "load half");
		runCmd(1'b0, FstcxCmd, 8'h00, $realtobits(-6.25), '0, 0,
			{32'h0, 32'hC0C80000}, "store single");  // -6.25
		runCmd(1'b1, FstcxCmd, 8'h03, $realtobits(0.75), '0, 0,
			{48'h0, 16'h3A00}, "store half");  // 0.75
		// one third as a single with the mantissa truncated
		runCmd(1'b0, FstcxCmd, 8'h08, third, '0, 0,
			{32'h3EAAAAAA, third[31:0]}, "store single high");
	endtask

	task automatic holdTest();
		int seen;
		logic [63:0] expected;
		expected = $realtobits(21.0);
		setLane(1'b0, Fpu3Cmd, XFmul, $realtobits(3.0), $realtobits(7.0));
		latchCmd();
		exHold = 1'b1;
		setLane(1'b1, Fpu3Cmd, XFmov, 64'h1234, '0);  // waits for release
		waitOk(seen);
		check(64'(seen), 64'd2, "held multiply hold cycles");
		repeat (3) begin
			@(negedge clock);
			check(64'(status), 64'(StatusOk), "status under exHold");
			check(result, expected, "result under exHold");
		end
		exHold = 1'b0;
		latchCmd();
		check(64'(status), 64'(StatusOk), "status after release");
		check(result, 64'h1234, "move after release");
	endtask

	initial begin
		lfsr = 8'd85;
		reset = 1'b1;
		opCmdA = '0;
		opCmdB = '0;
		ixtA = '0;
		ixtB = '0;
		valRsA = '0;
		valRtA = '0;
		valRsB = '0;
		valRtB = '0;
		srT = 1'b0;
		braFlush = 1'b0;
		exHold = 1'b0;
		repeat (4) @(negedge clock);
		reset = 1'b0;
		check(64'(status), 64'(StatusReady), "status after reset");
		laneTest();
		predicateTest();
		multiplyTest();
		packedTest();
		convertTest();
		holdTest();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: fpuExecute_checker.sv
/*
 * fpuExecuteChecker
 * bound assertions on the status level of the FPU execute slave
 */
`default_nettype none

module fpuExecuteChecker (
	input wire                             clock,
	input wire                             reset,
	input wire                             exHold,
	input wire [fpuPkg::StatusWidth-1:0]   status
);
	timeunit 1ns;
	timeprecision 1ps;
	import fpuPkg::*;

	logic [3:0] holdRun;  // consecutive self-hold cycles

	always_ff @(posedge clock) begin
		if (reset)
			holdRun <= 4'd0;
		else if (status == StatusHold && !exHold && holdRun != 4'hF)
			holdRun <= holdRun + 4'd1;
		else if (status != StatusHold || exHold)
			holdRun <= 4'd0;
	end

	readyAfterReset: assert property (@(posedge clock) reset |=> status == StatusReady)
		else $error("status is not ready in the cycle after reset");

	// 2'b11 is the one code with no meaning
	noUnusedCode: assert property (@(posedge clock) disable iff (reset) status != 2'b11)
		else $error("status took the unused code");

	holdBounded: assert property (@(posedge clock) disable iff (reset) holdRun <= 4'd4)
		else $error("hold status lasted more than 4 cycles without exHold");

endmodule

`default_nettype wire

// File: fpuExecute.sv
/*
 * fpuExecute
 * floating-point execute slave for a two-lane core, takes one FPU
 * command per cycle and returns a status level and one result word
 */
`default_nettype none

module fpuExecute #(
	parameter int MulLatency  = fpuPkg::MulLatency,
	parameter int PackedElems = fpuPkg::PackedElems
) (
	input  wire                  clock,
	input  wire                  reset,
	input  wire [7:0]            opCmdA,
	input  wire [7:0]            opCmdB,
	input  wire [7:0]            ixtA,
	input  wire [7:0]            ixtB,
	input  wire fpuPkg::fpWord   valRsA,
	input  wire fpuPkg::fpWord   valRtA,
	input  wire fpuPkg::fpWord   valRsB,
	input  wire fpuPkg::fpWord   valRtB,
	input  wire                  srT,
	input  wire                  braFlush,
	input  wire                  exHold,
	output logic [fpuPkg::StatusWidth-1:0] status,
	output logic [fpuPkg::WordWidth-1:0]   result
);
	import fpuPkg::*;

	fpWord rs;
	fpWord rt;
	logic [OpcodeWidth-1:0] opcode;
	logic [7:0] ixt;
	logic hold;
	logic advance;
	logic element;
	logic feedEnable;
	logic captureEnable;
	logic [2:0] select;
	logic [3:0] step;
	logic [WordWidth-1:0] ldSingle;
	logic [WordWidth-1:0] ldHalf;
	logic [WordWidth-1:0] elemRs;
	logic [WordWidth-1:0] elemRt;
	logic [WordWidth-1:0] product;
	logic [WordWidth-1:0] mulA;
	logic [WordWidth-1:0] mulB;
	logic [SingleWidth-1:0] stSingle;
	logic [SingleWidth-1:0] narrowed;
	logic [HalfWidth-1:0] stHalf;

	// packed elements go through the double multiplier one at a time
	assign mulA = feedEnable ? elemRs : rs.dbl;
	assign mulB = feedEnable ? elemRt : rt.dbl;

	fpuIssue issue0 (.clock, .reset, .opCmdA, .opCmdB, .ixtA, .ixtB,
		.valRsA, .valRtA, .valRsB, .valRtB, .srT, .braFlush, .exHold,
		.stall(hold), .opcode, .ixt, .rs, .rt);

	fpuControl #(.MulLatency(MulLatency), .PackedElems(PackedElems)) control0 (
		.clock, .reset, .opcode, .ixt, .step, .exHold, .hold, .advance,
		.element, .feedEnable, .captureEnable, .select, .status);

	fpuStepCounter counter0 (.clock, .reset, .advance, .exHold, .step);

	fpuConvert convert0 (.rs, .ixt, .rt, .element, .narrowIn(product),
		.ldSingle, .ldHalf, .stSingle, .stHalf, .elemRs, .elemRt,
		.narrowOut(narrowed));

	fpuMultiply multiply0 (.clock, .reset, .a(mulA), .b(mulB), .product);

	fpuResult result0 (.clock, .reset, .select, .captureEnable, .element,
		.narrowed, .product, .rs, .ldSingle, .ldHalf, .stSingle, .stHalf,
		.result);

endmodule

`default_nettype wire

// File: fpuResult.sv
/*
 * fpuResult
 * collects narrowed packed products per element and picks the
 * result word for the decoded command
 */
`default_nettype none

module fpuResult (
	input  wire                           clock,
	input  wire                           reset,
	input  wire [2:0]                     select,
	input  wire                           captureEnable,
	input  wire                           element,
	input  wire [fpuPkg::SingleWidth-1:0] narrowed,
	input  wire [fpuPkg::WordWidth-1:0]   product,
	input  wire fpuPkg::fpWord            rs,
	input  wire [fpuPkg::WordWidth-1:0]   ldSingle,
	input  wire [fpuPkg::WordWidth-1:0]   ldHalf,
	input  wire [fpuPkg::SingleWidth-1:0] stSingle,
	input  wire [fpuPkg::HalfWidth-1:0]   stHalf,
	output logic [fpuPkg::WordWidth-1:0]  result
);
	import fpuPkg::*;

	fpWord collect;  // packed multiply result under assembly

	always_ff @(posedge clock) begin
		if (reset)
			collect <= '0;
		else if (captureEnable)
			collect.sgl[element] <= narrowed;
	end

	always_comb begin
		case (select)
			SelProduct:  result = product;
			SelPacked:   result = collect.dbl;
			SelLdSingle: result = ldSingle;
			SelLdHalf:   result = ldHalf;
			SelStSingle: result = {{(WordWidth - SingleWidth){1'b0}}, stSingle};
			SelStHalf:   result = {{(WordWidth - HalfWidth){1'b0}}, stHalf};
			SelStHigh:   result = {stSingle, rs.sgl[0]};  // keeps low half of Rs
			default:     result = rs.dbl;
		endcase
	end

endmodule

`default_nettype wire

// File: fpuMultiply.sv
/*
 * fpuMultiply
 * two-stage double multiplier, truncating, with overflow to infinity
 * and underflow or denormal inputs to signed zero
 */
`default_nettype none

module fpuMultiply (
	input  wire                         clock,
	input  wire                         reset,
	input  wire [fpuPkg::WordWidth-1:0] a,
	input  wire [fpuPkg::WordWidth-1:0] b,
	output logic [fpuPkg::WordWidth-1:0] product
);

	logic signS1;
	logic [11:0] expS1;  // biased sum, zero marks a zero operand
	logic [105:0] mantS1;
	logic norm;
	logic [51:0] fracOut;
	logic signed [13:0] expAdj;

	// stage one
	always_ff @(posedge clock) begin
		if (reset) begin
			signS1 <= 1'b0;
			expS1 <= 12'd0;
		end else begin
			signS1 <= a[63] ^ b[63];
			if ((a[62:52] == 11'd0) || (b[62:52] == 11'd0))
				expS1 <= 12'd0;
			else
				expS1 <= {1'b0, a[62:52]} + {1'b0, b[62:52]};
		end
	end

	always_ff @(posedge clock) begin
		mantS1 <= {1'b1, a[51:0]} * {1'b1, b[51:0]};
	end

	assign norm = mantS1[105];  // product in [2,4)
	assign fracOut = norm ? mantS1[104:53] : mantS1[103:52];
	assign expAdj = $signed({2'b0, expS1}) - 14'sd1023 + $signed({13'b0, norm});

	// stage two
	always_ff @(posedge clock) begin
		if (reset)
			product <= 64'd0;
		else if (expAdj <= 0)
			product <= {signS1, 63'b0};
		else if (expAdj >= 14'sd2047)
			product <= {signS1, 11'h7FF, 52'b0};
		else
			product <= {signS1, expAdj[10:0], fracOut};
	end

endmodule

`default_nettype wire

// File: fpuConvert.sv
/*
 * fpuConvert
 * single/half to double widening for loads and packed elements,
 * double to single/half narrowing for stores and packed results
 */
`default_nettype none

module fpuConvert (
	input  wire fpuPkg::fpWord             rs,
	input  wire [7:0]                      ixt,
	input  wire fpuPkg::fpWord             rt,
	input  wire                            element,
	input  wire [fpuPkg::WordWidth-1:0]    narrowIn,
	output logic [fpuPkg::WordWidth-1:0]   ldSingle,
	output logic [fpuPkg::WordWidth-1:0]   ldHalf,
	output logic [fpuPkg::SingleWidth-1:0] stSingle,
	output logic [fpuPkg::HalfWidth-1:0]   stHalf,
	output logic [fpuPkg::WordWidth-1:0]   elemRs,
	output logic [fpuPkg::WordWidth-1:0]   elemRt,
	output logic [fpuPkg::SingleWidth-1:0] narrowOut
);
	import fpuPkg::*;

	logic [SingleWidth-1:0] pick;

	function automatic logic [63:0] s2d(input logic [31:0] x);
		logic [7:0] e;
		e = x[30:23];
		if (e == 8'h00)
			return {x[31], 63'b0};  // denormals flush
		else if (e == 8'hFF)
			return {x[31], 11'h7FF, x[22:0], 29'b0};
		else
			return {x[31], {3'b0, e} + 11'd896, x[22:0], 29'b0};
	endfunction

	function automatic logic [63:0] h2d(input logic [15:0] x);
		logic [4:0] e;
		e = x[14:10];
		if (e == 5'h00)
			return {x[15], 63'b0};
		else if (e == 5'h1F)
			return {x[15], 11'h7FF, x[9:0], 42'b0};
		else
			return {x[15], {6'b0, e} + 11'd1008, x[9:0], 42'b0};
	endfunction

	function automatic logic [31:0] d2s(input logic [63:0] x);
		logic [10:0] e;
		e = x[62:52];
		if (e == 11'h7FF)
			return {x[63], 8'hFF, x[51:29]};
		else if (e <= 11'd896)
			return {x[63], 31'b0};  // underflow to signed zero
		else if (e >= 11'd1151)
			return {x[63], 8'hFF, 23'b0};  // overflow to infinity
		else
			return {x[63], 8'(e - 11'd896), x[51:29]};
	endfunction

	function automatic logic [15:0] d2h(input logic [63:0] x);
		logic [10:0] e;
		e = x[62:52];
		if (e == 11'h7FF)
			return {x[63], 5'h1F, x[51:42]};
		else if (e <= 11'd1008)
			return {x[63], 15'b0};
		else if (e >= 11'd1039)
			return {x[63], 5'h1F, 10'b0};
		else
			return {x[63], 5'(e - 11'd1008), x[51:42]};
	endfunction

	assign pick = rs.sgl[ixt[3]];  // ixt bit 3 takes the high single
	assign ldSingle = s2d(pick);
	assign ldHalf = h2d(pick[HalfWidth-1:0]);
	assign stSingle = d2s(rs.dbl);
	assign stHalf = d2h(rs.dbl);
	assign elemRs = s2d(rs.sgl[element]);
	assign elemRt = s2d(rt.sgl[element]);
	assign narrowOut = d2s(narrowIn);

endmodule

`default_nettype wire

// File: fpuStepCounter.sv
/*
 * fpuStepCounter
 * hold-cycle count for multi-cycle commands, frozen under external hold
 */
`default_nettype none

module fpuStepCounter (
	input  wire        clock,
	input  wire        reset,
	input  wire        advance,
	input  wire        exHold,
	output logic [3:0] step
);

	always_ff @(posedge clock) begin
		if (reset)
			step <= 4'd0;
		else if (advance)
			step <= step + 4'd1;
		else if (!exHold)
			step <= 4'd0;  // done and released
	end

endmodule

`default_nettype wire

// File: fpuControl.sv
/*
 * fpuControl
 * decodes the latched command, sequences multi-cycle ops against the
 * step count and encodes the status level
 */
`default_nettype none

module fpuControl #(
	parameter int MulLatency  = fpuPkg::MulLatency,
	parameter int PackedElems = fpuPkg::PackedElems
) (
	input  wire                           clock,
	input  wire                           reset,
	input  wire [fpuPkg::OpcodeWidth-1:0] opcode,
	input  wire [7:0]                     ixt,
	input  wire [3:0]                     step,
	input  wire                           exHold,
	output logic                          hold,
	output logic                          advance,
	output logic                          element,
	output logic                          feedEnable,
	output logic                          captureEnable,
	output logic [2:0]                    select,
	output logic [fpuPkg::StatusWidth-1:0] status
);
	import fpuPkg::*;

	typedef enum logic [1:0] {Idle, Busy, Done} ctlState;

	ctlState state;
	ctlState nextState;
	logic valid;
	logic isPacked;
	logic [3:0] target;  // step count at which the result is ready

	always_comb begin
		valid = 1'b0;
		isPacked = 1'b0;
		select = SelRs;
		target = 4'd0;
		case (opcode)
			UcmdFpu3: begin
				valid = (ixt[3:0] == IxtFmul) || (ixt[3:0] == IxtFmov) ||
					(ixt[3:0] == IxtPmul);
				if (ixt[3:0] == IxtFmul) begin
					select = SelProduct;
					target = 4'(MulLatency);
				end else if (ixt[3:0] == IxtPmul) begin
					isPacked = 1'b1;
					select = SelPacked;
					target = 4'(PackedElems + MulLatency);
				end
			end
			UcmdFldcx: begin
				valid = (ixt[2:0] == IxtSingle[2:0]) || (ixt[2:0] == IxtHalf[2:0]);
				select = (ixt[2:0] == IxtHalf[2:0]) ? SelLdHalf : SelLdSingle;
			end
			UcmdFstcx: begin
				valid = 1'b1;
				case (ixt[3:0])
					IxtSingle:     select = SelStSingle;
					IxtHalf:       select = SelStHalf;
					IxtSingleHigh: select = SelStHigh;
					default:       valid = 1'b0;
				endcase
			end
			default: ;
		endcase
	end

	assign hold = valid && (state != Done) && (step < target);
	assign advance = hold;
	assign feedEnable = isPacked && (step < 4'(PackedElems));
	assign captureEnable = isPacked && (step >= 4'(MulLatency)) && (step < target);
	assign element = 1'(feedEnable ? step : step - 4'(MulLatency));
	assign status = hold ? StatusHold : (valid ? StatusOk : StatusReady);

	always_comb begin
		nextState = state;
		case (state)
			Idle, Busy: begin
				if (!hold)
					nextState = Idle;
				else if (step + 4'd1 >= target)
					nextState = Done;  // last hold cycle
				else
					nextState = Busy;
			end
			default: if (!exHold) nextState = Idle;  // Done waits out exHold
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= Idle;
		else
			state <= nextState;
	end

endmodule

`default_nettype wire

// File: fpuIssue.sv
/*
 * fpuIssue
 * picks the FPU command from the two lanes, lane A first, latches it
 * with its operands and applies the condition code and branch flush
 */
`default_nettype none

module fpuIssue (
	input  wire                clock,
	input  wire                reset,
	input  wire [7:0]          opCmdA,
	input  wire [7:0]          opCmdB,
	input  wire [7:0]          ixtA,
	input  wire [7:0]          ixtB,
	input  wire fpuPkg::fpWord valRsA,
	input  wire fpuPkg::fpWord valRtA,
	input  wire fpuPkg::fpWord valRsB,
	input  wire fpuPkg::fpWord valRtB,
	input  wire                srT,
	input  wire                braFlush,
	input  wire                exHold,
	input  wire                stall,
	output logic [fpuPkg::OpcodeWidth-1:0] opcode,
	output logic [7:0]         ixt,
	output fpuPkg::fpWord      rs,
	output fpuPkg::fpWord      rt
);
	import fpuPkg::*;

	logic laneA;
	logic laneB;
	logic load;
	logic [7:0] cmdL;
	logic flushL;
	logic enable;

	function automatic logic isFpu(input logic [OpcodeWidth-1:0] op);
		return (op == UcmdFpu3) || (op == UcmdFldcx) || (op == UcmdFstcx);
	endfunction

	assign laneA = isFpu(opCmdA[OpcodeWidth-1:0]);
	assign laneB = isFpu(opCmdB[OpcodeWidth-1:0]) && !laneA;  // A wins a tie
	assign load = !exHold && !stall;

	always_ff @(posedge clock) begin
		if (load) begin
			ixt <= laneB ? ixtB : ixtA;
			rs <= laneB ? valRsB : valRsA;
			rt <= laneB ? valRtB : valRtA;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			cmdL <= {CondNever, UcmdNop};
			flushL <= 1'b1;  // nothing runs out of reset
		end else if (load) begin
			cmdL <= laneB ? opCmdB : opCmdA;
			flushL <= braFlush;
		end
	end

	// condition is checked against the live T bit
	always_comb begin
		case (cmdL[7 -: CondWidth])
			CondAlways: enable = 1'b1;
			CondNever:  enable = 1'b0;
			CondTrue:   enable = srT;
			CondFalse:  enable = !srT;
		endcase
		if (flushL)
			enable = 1'b0;
	end

	assign opcode = enable ? cmdL[OpcodeWidth-1:0] : UcmdNop;

endmodule

`default_nettype wire

// File: fpuPkg.sv
/*
 * fpuPkg
 * shared widths, command and extension encodings, status codes
 * and the 64-bit operand word for the FPU execute slave
 */
`default_nettype none

package fpuPkg;

	localparam int WordWidth   = 64;
	localparam int SingleWidth = 32;
	localparam int HalfWidth   = 16;
	localparam int OpcodeWidth = 6;
	localparam int CondWidth   = 2;
	localparam int StatusWidth = 2;

	// opcode field of the command byte
	localparam logic [OpcodeWidth-1:0] UcmdNop   = 6'h00;
	localparam logic [OpcodeWidth-1:0] UcmdFpu3  = 6'h14;
	localparam logic [OpcodeWidth-1:0] UcmdFldcx = 6'h15;
	localparam logic [OpcodeWidth-1:0] UcmdFstcx = 6'h16;

	// condition field, top two command bits
	localparam logic [CondWidth-1:0] CondAlways = 2'b00;
	localparam logic [CondWidth-1:0] CondNever  = 2'b01;
	localparam logic [CondWidth-1:0] CondTrue   = 2'b10;
	localparam logic [CondWidth-1:0] CondFalse  = 2'b11;

	localparam logic [3:0] IxtFmul       = 4'h2;
	localparam logic [3:0] IxtFmov       = 4'h4;
	localparam logic [3:0] IxtPmul       = 4'h7;
	localparam logic [3:0] IxtSingle     = 4'h0;
	localparam logic [3:0] IxtHalf       = 4'h3;
	localparam logic [3:0] IxtSingleHigh = 4'h8;

	localparam logic [StatusWidth-1:0] StatusReady = 2'b00;
	localparam logic [StatusWidth-1:0] StatusOk    = 2'b01;
	localparam logic [StatusWidth-1:0] StatusHold  = 2'b10;

	localparam int MulLatency  = 2;
	localparam int PackedElems = 2;

	// result word selection
	localparam logic [2:0] SelRs       = 3'd0;
	localparam logic [2:0] SelProduct  = 3'd1;
	localparam logic [2:0] SelPacked   = 3'd2;
	localparam logic [2:0] SelLdSingle = 3'd3;
	localparam logic [2:0] SelLdHalf   = 3'd4;
	localparam logic [2:0] SelStSingle = 3'd5;
	localparam logic [2:0] SelStHalf   = 3'd6;
	localparam logic [2:0] SelStHigh   = 3'd7;

	typedef union packed {
		logic [WordWidth-1:0] dbl;
		logic [PackedElems-1:0][SingleWidth-1:0] sgl;  // element 0 in low half
	} fpWord;

endpackage

`default_nettype wire
